//--- rtl/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes, bits 6:0 of the instruction
  typedef enum logic [6:0] {
    opc_load     = 7'b0000011,
    opc_misc_mem = 7'b0001111,
    opc_op_imm   = 7'b0010011,
    opc_auipc    = 7'b0010111,
    opc_store    = 7'b0100011,
    opc_op       = 7'b0110011,
    opc_lui      = 7'b0110111,
    opc_branch   = 7'b1100011,
    opc_jalr     = 7'b1100111,
    opc_jal      = 7'b1101111,
    opc_system   = 7'b1110011
  } opcode_e;

  // one entry per supported operation
  typedef enum logic [4:0] {
    op_illegal,
    op_nop,
    op_add,
    op_sub,
    op_sll,
    op_slt,
    op_sltu,
    op_xor,
    op_srl,
    op_sra,
    op_or,
    op_and,
    op_beq,
    op_bne,
    op_blt,
    op_bge,
    op_bltu,
    op_bgeu,
    op_lb,
    op_lh,
    op_lw,
    op_lbu,
    op_lhu,
    op_sb,
    op_sh,
    op_sw,
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_ecall
  } op_e;

  typedef struct packed {
    op_e      op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;        // already sign-extended
    logic     use_imm;    // second operand comes from imm
    logic     writes_rd;
  } decoded_t;

  // addr is word aligned, be selects the written bytes
  typedef struct packed {
    word_t      addr;
    word_t      wdata;
    logic [3:0] be;
  } dmem_req_t;

  function automatic logic is_load(op_e op);
    return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
  endfunction

  function automatic logic is_store(op_e op);
    return op inside {op_sb, op_sh, op_sw};
  endfunction

endpackage

//--- rtl/rv_decoder.sv
module rv_decoder #(
  parameter int NUM_REGS = 32
) (
  input  rv_pkg::word_t    insn,
  output rv_pkg::decoded_t dec
);

  rv_pkg::opcode_e  opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  rv_pkg::reg_idx_t rd_f;
  rv_pkg::reg_idx_t rs1_f;
  rv_pkg::reg_idx_t rs2_f;

  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_s;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_j;
  rv_pkg::word_t imm_u;

  rv_pkg::op_e   op;
  rv_pkg::word_t imm;
  logic          use_imm;
  logic          writes;
  logic          uses_rs1;
  logic          uses_rs2;

  assign opcode = rv_pkg::opcode_e'(insn[6:0]);
  assign rd_f   = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1_f  = insn[19:15];
  assign rs2_f  = insn[24:20];
  assign funct7 = insn[31:25];

  // immediate formats
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    op       = rv_pkg::op_illegal;
    imm      = imm_i;
    use_imm  = 1'b0;
    writes   = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      rv_pkg::opc_lui: begin
        op     = rv_pkg::op_lui;
        imm    = imm_u;
        writes = 1'b1;
      end
      rv_pkg::opc_auipc: begin
        op     = rv_pkg::op_auipc;
        imm    = imm_u;
        writes = 1'b1;
      end
      rv_pkg::opc_jal: begin
        op     = rv_pkg::op_jal;
        imm    = imm_j;
        writes = 1'b1;
      end
      rv_pkg::opc_jalr: begin
        if (funct3 == 3'b000) begin
          op       = rv_pkg::op_jalr;
          writes   = 1'b1;
          uses_rs1 = 1'b1;
        end
      end
      rv_pkg::opc_branch: begin
        imm      = imm_b;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        case (funct3)
          3'b000:  op = rv_pkg::op_beq;
          3'b001:  op = rv_pkg::op_bne;
          3'b100:  op = rv_pkg::op_blt;
          3'b101:  op = rv_pkg::op_bge;
          3'b110:  op = rv_pkg::op_bltu;
          3'b111:  op = rv_pkg::op_bgeu;
          default: op = rv_pkg::op_illegal;
        endcase
      end
      rv_pkg::opc_load: begin
        use_imm  = 1'b1;
        writes   = 1'b1;
        uses_rs1 = 1'b1;
        case (funct3)
          3'b000:  op = rv_pkg::op_lb;
          3'b001:  op = rv_pkg::op_lh;
          3'b010:  op = rv_pkg::op_lw;
          3'b100:  op = rv_pkg::op_lbu;
          3'b101:  op = rv_pkg::op_lhu;
          default: op = rv_pkg::op_illegal;
        endcase
      end
      rv_pkg::opc_store: begin
        imm      = imm_s;
        use_imm  = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        case (funct3)
          3'b000:  op = rv_pkg::op_sb;
          3'b001:  op = rv_pkg::op_sh;
          3'b010:  op = rv_pkg::op_sw;
          default: op = rv_pkg::op_illegal;
        endcase
      end
      rv_pkg::opc_op_imm: begin
        use_imm  = 1'b1;
        writes   = 1'b1;
        uses_rs1 = 1'b1;
        case (funct3)
          3'b000: op = rv_pkg::op_add;
          3'b010: op = rv_pkg::op_slt;
          3'b011: op = rv_pkg::op_sltu;
          3'b100: op = rv_pkg::op_xor;
          3'b110: op = rv_pkg::op_or;
          3'b111: op = rv_pkg::op_and;
          3'b001: if (funct7 == 7'b0000000) op = rv_pkg::op_sll;
          default: begin
            // funct3 101, shift right
            if (funct7 == 7'b0000000) op = rv_pkg::op_srl;
            else if (funct7 == 7'b0100000) op = rv_pkg::op_sra;
          end
        endcase
      end
      rv_pkg::opc_op: begin
        writes   = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: op = rv_pkg::op_add;
          10'b0100000_000: op = rv_pkg::op_sub;
          10'b0000000_001: op = rv_pkg::op_sll;
          10'b0000000_010: op = rv_pkg::op_slt;
          10'b0000000_011: op = rv_pkg::op_sltu;
          10'b0000000_100: op = rv_pkg::op_xor;
          10'b0000000_101: op = rv_pkg::op_srl;
          10'b0100000_101: op = rv_pkg::op_sra;
          10'b0000000_110: op = rv_pkg::op_or;
          10'b0000000_111: op = rv_pkg::op_and;
          default:         op = rv_pkg::op_illegal;
        endcase
      end
      // fence has no ordering work to do in this core
      rv_pkg::opc_misc_mem: op = rv_pkg::op_nop;
      rv_pkg::opc_system: begin
        if (insn[31:7] == 25'd0) op = rv_pkg::op_ecall;
      end
      default: op = rv_pkg::op_illegal;
    endcase

    // registers beyond NUM_REGS do not exist (rv32e case)
    if ((writes && int'(rd_f) >= NUM_REGS) ||
        (uses_rs1 && int'(rs1_f) >= NUM_REGS) ||
        (uses_rs2 && int'(rs2_f) >= NUM_REGS)) begin
      op = rv_pkg::op_illegal;
    end
    if (op == rv_pkg::op_illegal) begin
      writes   = 1'b0;
      uses_rs1 = 1'b0;
      uses_rs2 = 1'b0;
    end
  end

  // unused index fields go to x0 so the register file never reads out of range
  assign dec.op        = op;
  assign dec.rd        = writes ? rd_f : '0;
  assign dec.rs1       = uses_rs1 ? rs1_f : '0;
  assign dec.rs2       = uses_rs2 ? rs2_f : '0;
  assign dec.imm       = imm;
  assign dec.use_imm   = use_imm;
  assign dec.writes_rd = writes;

endmodule

//--- rtl/rv_regfile.sv
module rv_regfile #(
  parameter int NUM_REGS = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    wb_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);

  rv_pkg::word_t regs [NUM_REGS];
  logic          wr_en;

  // x0 is never written, so it keeps its reset value of zero
  assign wr_en = dec.writes_rd && dec.rd != '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[dec.rd] <= wb_data;
    end
  end

  assign rs1_data = regs[dec.rs1];
  assign rs2_data = regs[dec.rs2];

  // a register written in one cycle reads back its new value in the next
  a_write_then_read: assert property (@(posedge clk) disable iff (rst)
    wr_en |=> (dec.rs1 != $past(dec.rd) || rs1_data == $past(wb_data)))
    else $error("regfile: x%0d did not read back its written value", $past(dec.rd));

endmodule

//--- rtl/rv_execute.sv
module rv_execute (
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    pc,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  input  rv_pkg::word_t    load_value,
  output rv_pkg::word_t    wb_data
);

  rv_pkg::word_t op2;
  rv_pkg::word_t alu;
  logic [4:0]    shamt;

  assign op2   = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op2[4:0];

  // integer operations
  always_comb begin
    case (dec.op)
      rv_pkg::op_add:  alu = rs1_data + op2;
      rv_pkg::op_sub:  alu = rs1_data - op2;
      rv_pkg::op_sll:  alu = rs1_data << shamt;
      rv_pkg::op_slt:  alu = rv_pkg::word_t'($signed(rs1_data) < $signed(op2));
      rv_pkg::op_sltu: alu = rv_pkg::word_t'(rs1_data < op2);
      rv_pkg::op_xor:  alu = rs1_data ^ op2;
      rv_pkg::op_srl:  alu = rs1_data >> shamt;
      rv_pkg::op_sra:  alu = rv_pkg::word_t'($signed(rs1_data) >>> shamt);
      rv_pkg::op_or:   alu = rs1_data | op2;
      rv_pkg::op_and:  alu = rs1_data & op2;
      default:         alu = '0;
    endcase
  end

  // writeback select
  always_comb begin
    case (dec.op)
      rv_pkg::op_lui:   wb_data = dec.imm;
      rv_pkg::op_auipc: wb_data = pc + dec.imm;
      // link value for both jumps
      rv_pkg::op_jal,
      rv_pkg::op_jalr:  wb_data = pc + 32'd4;
      default: begin
        if (rv_pkg::is_load(dec.op)) begin
          wb_data = load_value;
        end else begin
          wb_data = alu;
        end
      end
    endcase
  end

endmodule

//--- rtl/rv_lsu.sv
module rv_lsu (
  input  rv_pkg::decoded_t  dec,
  input  rv_pkg::word_t     rs1_data,
  input  rv_pkg::word_t     rs2_data,
  input  rv_pkg::word_t     load_data,
  output rv_pkg::dmem_req_t dmem_req,
  output rv_pkg::word_t     load_value
);

  rv_pkg::word_t ea;
  rv_pkg::word_t wdata;
  rv_pkg::word_t lane;
  logic [3:0]    be;
  logic [1:0]    offset;

  assign ea     = rs1_data + dec.imm;
  assign offset = ea[1:0];

  // store data is replicated so every lane holds it, be picks the lane
  always_comb begin
    wdata = rs2_data;
    be    = 4'b0000;
    case (dec.op)
      rv_pkg::op_sb: begin
        wdata = {4{rs2_data[7:0]}};
        be    = 4'b0001 << offset;
      end
      rv_pkg::op_sh: begin
        wdata = {2{rs2_data[15:0]}};
        be    = 4'b0011 << {offset[1], 1'b0};
      end
      rv_pkg::op_sw: be = 4'b1111;
      default: be = 4'b0000;
    endcase
  end

  assign dmem_req = '{addr: {ea[31:2], 2'b00}, wdata: wdata, be: be};

  // bring the addressed lane down to bit 0
  assign lane = load_data >> {offset, 3'b000};

  always_comb begin
    case (dec.op)
      rv_pkg::op_lb:  load_value = {{24{lane[7]}}, lane[7:0]};
      rv_pkg::op_lh:  load_value = {{16{lane[15]}}, lane[15:0]};
      rv_pkg::op_lbu: load_value = {24'b0, lane[7:0]};
      rv_pkg::op_lhu: load_value = {16'b0, lane[15:0]};
      default:        load_value = lane;
    endcase
  end

  // halfwords on even addresses, words on multiples of four
  always_comb begin
    if (rv_pkg::is_load(dec.op) || rv_pkg::is_store(dec.op)) begin
      a_aligned: assert final (
        !((dec.op inside {rv_pkg::op_lh, rv_pkg::op_lhu, rv_pkg::op_sh}) && offset[0]) &&
        !((dec.op inside {rv_pkg::op_lw, rv_pkg::op_sw}) && offset != 2'b00))
        else $error("lsu: misaligned access to %h", ea);
    end
  end

endmodule

//--- rtl/rv_pc_unit.sv
module rv_pc_unit #(
  parameter rv_pkg::word_t RESET_PC = 32'h0
) (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  output rv_pkg::word_t    pc,
  output logic             halt
);

  rv_pkg::word_t pc_next;
  rv_pkg::word_t target;
  rv_pkg::word_t jalr_target;
  logic          taken;

  always_comb begin
    case (dec.op)
      rv_pkg::op_beq:  taken = rs1_data == rs2_data;
      rv_pkg::op_bne:  taken = rs1_data != rs2_data;
      rv_pkg::op_blt:  taken = $signed(rs1_data) < $signed(rs2_data);
      rv_pkg::op_bge:  taken = $signed(rs1_data) >= $signed(rs2_data);
      rv_pkg::op_bltu: taken = rs1_data < rs2_data;
      rv_pkg::op_bgeu: taken = rs1_data >= rs2_data;
      default:         taken = 1'b0;
    endcase
  end

  // branch and jal share the pc-relative target
  assign target      = pc + dec.imm;
  assign jalr_target = (rs1_data + dec.imm) & ~rv_pkg::word_t'(1);
  assign halt        = dec.op == rv_pkg::op_ecall;

  always_comb begin
    case (dec.op)
      rv_pkg::op_jal:   pc_next = target;
      rv_pkg::op_jalr:  pc_next = jalr_target;
      rv_pkg::op_ecall: pc_next = pc;
      default:          pc_next = taken ? target : pc + 32'd4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // decoded immediates and jalr operands must keep fetches word aligned
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc_unit: misaligned pc %h", pc);

endmodule

//--- rtl/rv_core_top.sv
module rv_core_top #(
  parameter int            NUM_REGS = 32,
  parameter rv_pkg::word_t RESET_PC = 32'h0
) (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::word_t     insn,
  input  rv_pkg::word_t     load_data,
  output rv_pkg::word_t     pc,
  output rv_pkg::dmem_req_t dmem_req,
  output logic              halt
);

  rv_pkg::decoded_t dec;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    wb_data;
  rv_pkg::word_t    load_value;

  rv_decoder #(
    .NUM_REGS(NUM_REGS)
  ) u_rv_decoder (
    .insn(insn),
    .dec (dec)
  );

  rv_regfile #(
    .NUM_REGS(NUM_REGS)
  ) u_rv_regfile (
    .clk     (clk),
    .rst     (rst),
    .dec     (dec),
    .wb_data (wb_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  rv_execute u_rv_execute (
    .dec       (dec),
    .pc        (pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .load_value(load_value),
    .wb_data   (wb_data)
  );

  rv_lsu u_rv_lsu (
    .dec       (dec),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .load_data (load_data),
    .dmem_req  (dmem_req),
    .load_value(load_value)
  );

  rv_pc_unit #(
    .RESET_PC(RESET_PC)
  ) u_rv_pc_unit (
    .clk     (clk),
    .rst     (rst),
    .dec     (dec),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .pc      (pc),
    .halt    (halt)
  );

endmodule

//--- bench/rv_ref_model.svh
// instruction encoders for the base formats
function automatic rv_pkg::word_t enc_i(int imm, int rs1, int f3, int rd, logic [6:0] opc);
  return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
endfunction

function automatic rv_pkg::word_t enc_u(int imm20, int rd, logic [6:0] opc);
  return {imm20[19:0], rd[4:0], opc};
endfunction

function automatic rv_pkg::word_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
  return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic rv_pkg::word_t enc_s(int imm, int rs2, int rs1, int f3);
  return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
endfunction

function automatic rv_pkg::word_t enc_b(int imm, int rs2, int rs1, int f3);
  return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic rv_pkg::word_t enc_j(int imm, int rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

// lui, auipc, op-imm or op with random fields
function automatic rv_pkg::word_t random_alu_insn();
  int kind, rd, rs1, rs2, f3, f7, imm;
  kind = $urandom % 4;
  rd   = $urandom % 32;
  rs1  = $urandom % 32;
  rs2  = $urandom % 32;
  f3   = $urandom % 8;
  f7   = 0;
  if ((f3 == 0 || f3 == 5) && $urandom % 2 == 1) f7 = 32;
  // shifts carry funct7 in the upper immediate bits
  if (f3 == 1 || f3 == 5) imm = f7 * 32 + $urandom % 32;
  else imm = $urandom % 4096;
  last_rd = rd;
  case (kind)
    0: return enc_u($urandom, rd, 7'b0110111);
    1: return enc_u($urandom, rd, 7'b0010111);
    2: return enc_i(imm, rs1, f3, rd, 7'b0010011);
    default: return enc_r(f7, rs2, rs1, f3, rd);
  endcase
endfunction

// every result is stored right after it is computed
function automatic rv_pkg::word_t integer_insn(int step);
  if (step % 2 == 1) return enc_s(($urandom % 256) * 4, last_rd, 0, 2);
  return random_alu_insn();
endfunction

// store, load, then store of the loaded value, all in a small window
function automatic rv_pkg::word_t load_insn(int step);
  int width, addr, f3;
  width = $urandom % 3;
  addr  = ($urandom % 64) & ~((1 << width) - 1);
  f3    = width;
  case (step % 3)
    0: return enc_s(addr, 1 + $urandom % 31, 0, width);
    1: begin
      if (width < 2 && $urandom % 2 == 1) f3 = width + 4;
      last_rd = 1 + $urandom % 31;
      return enc_i(addr, 0, f3, last_rd, 7'b0000011);
    end
    default: return enc_s(($urandom % 256) * 4, last_rd, 0, 2);
  endcase
endfunction

// operands live in x5..x12, link values in x1
function automatic rv_pkg::word_t control_insn(int step);
  int ra, rb, r, far, f3;
  ra  = 5 + $urandom % 8;
  rb  = 5 + $urandom % 8;
  r   = $urandom % 4096;
  far = $urandom % 2048;
  f3  = r % 6;
  if (f3 >= 2) f3 = f3 + 2;
  case (step % 5)
    0: return enc_u($urandom, ra, 7'b0110111);
    // plain copies make equal operands common
    1: return enc_i((r % 2 == 0) ? 0 : r, rb, 0, ra, 7'b0010011);
    2: return enc_b(((r % 64) - 32) * 4, rb, ra, f3);
    3: begin
      if (r % 2 == 0) return enc_j((far - 1024) * 4, 1);
      return enc_i((far % 512) * 4, 0, 0, 1, 7'b1100111);
    end
    default: return enc_s(($urandom % 256) * 4, 1, 0, 2);
  endcase
endfunction

function automatic logic branch_taken(logic [2:0] f3, rv_pkg::word_t a, rv_pkg::word_t b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return $signed(a) >= $signed(b);
    3'd6: return a < b;
    3'd7: return a >= b;
    default: return 1'b0;
  endcase
endfunction

function automatic rv_pkg::word_t alu_result(logic [2:0] f3, logic alt,
                                             rv_pkg::word_t a, rv_pkg::word_t b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// one instruction on the shadow registers and memory
function automatic void execute_ref(input rv_pkg::word_t in, output rv_pkg::word_t next_pc,
                                    output rv_pkg::dmem_req_t req, output logic hlt,
                                    output logic mem_access);
  rv_pkg::word_t a, b, imm_i, imm_s, ea, res, lane;
  logic [2:0] f3;
  logic       wr;
  a     = sh_regs[in[19:15]];
  b     = sh_regs[in[24:20]];
  f3    = in[14:12];
  imm_i = {{20{in[31]}}, in[31:20]};
  imm_s = {{20{in[31]}}, in[31:25], in[11:7]};
  ea    = '0;
  res   = '0;
  wr    = 1'b1;
  req   = '0;
  hlt   = 1'b0;
  mem_access = 1'b0;
  next_pc    = sh_pc + 32'd4;
  case (in[6:0])
    7'b0110111: res = {in[31:12], 12'b0};
    7'b0010111: res = sh_pc + {in[31:12], 12'b0};
    7'b1101111: begin
      res     = sh_pc + 32'd4;
      next_pc = sh_pc + {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
    end
    7'b1100111: begin
      res     = sh_pc + 32'd4;
      next_pc = (a + imm_i) & ~32'd1;
    end
    7'b1100011: begin
      wr = 1'b0;
      if (branch_taken(f3, a, b)) begin
        next_pc = sh_pc + {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
      end
    end
    7'b0000011: begin
      ea         = a + imm_i;
      mem_access = 1'b1;
      req.addr   = {ea[31:2], 2'b00};
      lane       = sh_mem[ea[9:2]] >> {ea[1:0], 3'b000};
      case (f3)
        3'd0: res = {{24{lane[7]}}, lane[7:0]};
        3'd1: res = {{16{lane[15]}}, lane[15:0]};
        3'd4: res = {24'd0, lane[7:0]};
        3'd5: res = {16'd0, lane[15:0]};
        default: res = lane;
      endcase
    end
    7'b0100011: begin
      wr         = 1'b0;
      ea         = a + imm_s;
      mem_access = 1'b1;
      req.addr   = {ea[31:2], 2'b00};
      case (f3)
        3'd0: begin
          req.be    = 4'b0001 << ea[1:0];
          req.wdata = {4{b[7:0]}};
        end
        3'd1: begin
          req.be    = 4'b0011 << ea[1:0];
          req.wdata = {2{b[15:0]}};
        end
        default: begin
          req.be    = 4'b1111;
          req.wdata = b;
        end
      endcase
      for (int i = 0; i < 4; i++) begin
        if (req.be[i]) sh_mem[ea[9:2]][8*i +: 8] = req.wdata[8*i +: 8];
      end
    end
    7'b0010011: res = alu_result(f3, f3 == 3'd5 && in[30], a, imm_i);
    7'b0110011: res = alu_result(f3, in[30], a, b);
    7'b1110011: begin
      wr = 1'b0;
      if (in == 32'h0000_0073) begin
        hlt     = 1'b1;
        next_pc = sh_pc;
      end
    end
    // fence and unknown encodings
    default: wr = 1'b0;
  endcase
  if (wr && in[11:7] != 5'd0) sh_regs[in[11:7]] = res;
endfunction

//--- bench/rv_core_tb.sv
module rv_core_tb;

  localparam int            num_regs   = 32;
  localparam rv_pkg::word_t reset_pc   = 32'h0;
  localparam int            mem_words  = 256;
  localparam int            max_cycles = 1500;

  logic              clk;
  logic              rst;
  rv_pkg::word_t     insn;
  rv_pkg::word_t     load_data;
  rv_pkg::word_t     pc;
  rv_pkg::dmem_req_t dmem_req;
  logic              halt;

  rv_pkg::word_t dmem [mem_words];

  // shadow state of the reference model
  rv_pkg::word_t sh_regs [32];
  rv_pkg::word_t sh_mem [mem_words];
  rv_pkg::word_t sh_pc;
  int            last_rd;

  rv_pkg::word_t     exp_pc;
  rv_pkg::dmem_req_t exp_req;
  logic              exp_halt;
  logic              exp_mem;
  logic              check_en;

  int err_count;
  int check_count;
  int cycle_count;
  int test_count;

  `include "rv_ref_model.svh"

  rv_core_top #(
    .NUM_REGS(num_regs),
    .RESET_PC(reset_pc)
  ) u_rv_core_top (
    .clk      (clk),
    .rst      (rst),
    .insn     (insn),
    .load_data(load_data),
    .pc       (pc),
    .dmem_req (dmem_req),
    .halt     (halt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // data memory model
  assign load_data = dmem[dmem_req.addr[9:2]];

  always @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < 4; i++) begin
        if (dmem_req.be[i]) dmem[dmem_req.addr[9:2]][8*i +: 8] <= dmem_req.wdata[8*i +: 8];
      end
    end
  end

  function automatic rv_pkg::word_t fill_word(int idx);
    return 32'h9e37_79b9 * (idx + 1);
  endfunction

  task automatic report_mismatch(input string name, input rv_pkg::word_t expected,
                                 input rv_pkg::word_t actual);
    err_count++;
    $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
  endtask

  // compare against the reference at each rising edge
  always @(posedge clk) begin
    if (check_en) begin
      check_count++;
      assert (pc === exp_pc)
        else report_mismatch("pc", exp_pc, pc);
      assert (halt === exp_halt)
        else report_mismatch("halt", 32'(exp_halt), 32'(halt));
      assert (dmem_req.be === exp_req.be)
        else report_mismatch("dmem_req.be", 32'(exp_req.be), 32'(dmem_req.be));
      if (exp_mem) begin
        assert (dmem_req.addr === exp_req.addr)
          else report_mismatch("dmem_req.addr", exp_req.addr, dmem_req.addr);
      end
      if (exp_req.be != 4'b0000) begin
        assert (dmem_req.wdata === exp_req.wdata)
          else report_mismatch("dmem_req.wdata", exp_req.wdata, dmem_req.wdata);
      end
    end
  end

  function automatic rv_pkg::word_t pick_insn(int kind, int step, int count);
    case (kind)
      0: return integer_insn(step);
      1: return load_insn(step);
      2: return control_insn(step);
      default: begin
        // ecall for the last ten cycles
        if (step >= count - 10) return 32'h0000_0073;
        return integer_insn(step);
      end
    endcase
  endfunction

  task automatic print_result(input string name, input int checks_before, input int errs_before);
    test_count++;
    $display("test %-8s %0d checks, %0d errors", name, check_count - checks_before,
             err_count - errs_before);
  endtask

  // called at a falling edge, returns at a falling edge
  task automatic run_test(input string name, input int kind, input int count);
    int            errs_before;
    int            checks_before;
    rv_pkg::word_t next_insn;
    rv_pkg::word_t next_pc;
    errs_before   = err_count;
    checks_before = check_count;
    for (int step = 0; step < count; step++) begin
      next_insn = pick_insn(kind, step, count);
      exp_pc    = sh_pc;
      execute_ref(next_insn, next_pc, exp_req, exp_halt, exp_mem);
      sh_pc     = next_pc;
      insn      = next_insn;
      check_en  = 1'b1;
      @(posedge clk);
      @(negedge clk);
    end
    check_en = 1'b0;
    print_result(name, checks_before, errs_before);
  endtask

  initial begin
    int errs_before;
    int checks_before;
    void'($urandom(62750));
    rst         = 1'b1;
    insn        = '0;
    check_en    = 1'b0;
    exp_pc      = '0;
    exp_req     = '0;
    exp_halt    = 1'b0;
    exp_mem     = 1'b0;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    last_rd     = 0;
    sh_pc       = reset_pc;
    for (int i = 0; i < 32; i++) begin
      sh_regs[i] = '0;
    end
    for (int i = 0; i < mem_words; i++) begin
      dmem[i]   = fill_word(i);
      sh_mem[i] = fill_word(i);
    end

    // reset state is checked once pc has left X
    errs_before   = err_count;
    checks_before = check_count;
    repeat (2) @(posedge clk);
    @(negedge clk);
    exp_pc   = reset_pc;
    check_en = 1'b1;
    repeat (14) @(posedge clk);
    @(negedge clk);
    check_en = 1'b0;
    rst      = 1'b0;
    print_result("reset", checks_before, errs_before);

    run_test("integer", 0, 160);
    run_test("load", 1, 160);
    run_test("control", 2, 160);
    run_test("halt", 3, 40);

    $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // run limit, well above the 536 cycles the tests need
  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not end within %0d cycles", max_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- compile.f
+incdir+bench
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_lsu.sv
rtl/rv_pc_unit.sv
rtl/rv_core_top.sv
bench/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= rv_core_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
